// File: Makefile
TOP = branch_predictor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
	    --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then \
	    echo "Simulation FAILED"; \
	    exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// File: dv/branch_predictor_checker.sv
// Concurrent assertions on the branch predictor outputs and their bind to the top level.
`timescale 1ns/1ps

module branch_predictor_checker import branch_pkg::*; #(
    parameter int ghr_bits = 5
) (
    input logic                clk,
    input logic                rst_n_i,
    input logic [XLEN-1:0]     pc_i,
    input logic                hit_o,
    input logic                predict_taken_o,
    input logic [XLEN-1:0]     target_o,
    input logic [ghr_bits-1:0] pht_index_o,
    input logic                ghr_clear_i
);

    taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        predict_taken_o |-> hit_o)
        else $error("predict_taken_o high while hit_o is low");

    miss_target_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        !hit_o |-> (target_o == '0))
        else $error("target_o not zero on a BTB miss");

    // Empty history leaves only the PC bits in the index.
    clear_index_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        ghr_clear_i |=> (pht_index_o == pc_i[PC_LSB +: ghr_bits]))
        else $error("pht_index_o differs from PC bits after a history clear");

endmodule

bind branch_predictor branch_predictor_checker #(
    .ghr_bits        (ghr_bits)
) checker_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .pc_i            (pc_i),
    .hit_o           (hit_o),
    .predict_taken_o (predict_taken_o),
    .target_o        (target_o),
    .pht_index_o     (pht_index_o),
    .ghr_clear_i     (ghr_clear_i)
);

// File: dv/branch_predictor_tb.sv
// Testbench for the branch predictor with reference model, directed tests and watchdog.
`timescale 1ns/1ps

module branch_predictor_tb import branch_pkg::*;;

    localparam int BTB_ENTRIES   = 32;
    localparam int GHR_BITS      = 5;
    localparam int BTB_IDX_BITS  = $clog2(BTB_ENTRIES);
    localparam int WORD_LSB      = 2;
    localparam int CLK_PERIOD    = 4;
    localparam int TEST_CYCLES   = 260;
    localparam int MARGIN_CYCLES = 100;

    logic                clk;
    logic                rst_n_i;
    logic [XLEN-1:0]     pc_i;
    logic                hit_o;
    logic                predict_taken_o;
    logic [XLEN-1:0]     target_o;
    logic [GHR_BITS-1:0] pht_index_o;
    logic                update_valid_i;
    logic [XLEN-1:0]     update_pc_i;
    opcode_e             update_op_i;
    logic [XLEN-1:0]     update_target_i;
    logic                update_taken_i;
    logic [GHR_BITS-1:0] update_pht_index_i;
    logic                ghr_clear_i;

    // Reference model state.
    logic                m_valid  [BTB_ENTRIES];
    logic [XLEN-1:0]     m_tag    [BTB_ENTRIES];
    logic [XLEN-1:0]     m_target [BTB_ENTRIES];
    logic                m_jump   [BTB_ENTRIES];
    logic                m_branch [BTB_ENTRIES];
    counter_e            m_pht    [1 << GHR_BITS];
    logic [GHR_BITS-1:0] m_ghr;

    logic [31:0] lfsr_state = 32'he888;
    int          error_count = 0;

    always #2 clk = ~clk;

    branch_predictor #(
        .btb_entries        (BTB_ENTRIES),
        .ghr_bits           (GHR_BITS)
    ) branch_predictor_inst (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .pc_i               (pc_i),
        .hit_o              (hit_o),
        .predict_taken_o    (predict_taken_o),
        .target_o           (target_o),
        .pht_index_o        (pht_index_o),
        .update_valid_i     (update_valid_i),
        .update_pc_i        (update_pc_i),
        .update_op_i        (update_op_i),
        .update_target_i    (update_target_i),
        .update_taken_i     (update_taken_i),
        .update_pht_index_i (update_pht_index_i),
        .ghr_clear_i        (ghr_clear_i)
    );

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("error at %0t: %s expected %0b actual %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input logic [GHR_BITS-1:0] exp,
                               input logic [GHR_BITS-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << GHR_BITS); i++) begin
            m_pht[i] = COUNTER_RESET;
        end
        m_ghr = '0;
    endtask

    // Applies the update that the DUT samples at the coming rising edge.
    task automatic model_apply();
        logic [BTB_IDX_BITS-1:0] widx;
        logic                    is_branch;
        widx = update_pc_i[WORD_LSB +: BTB_IDX_BITS];
        is_branch = update_valid_i && (update_op_i == OP_BRANCH);
        if (update_valid_i && (update_op_i != OP_OTHER)) begin
            m_valid[widx]  = 1'b1;
            m_tag[widx]    = update_pc_i >> (BTB_IDX_BITS + WORD_LSB);
            m_target[widx] = update_target_i;
            m_jump[widx]   = (update_op_i == OP_JAL) || (update_op_i == OP_JALR);
            m_branch[widx] = (update_op_i == OP_BRANCH);
        end
        if (is_branch) begin
            if (update_taken_i && (m_pht[update_pht_index_i] != STRONG_T)) begin
                m_pht[update_pht_index_i] = counter_e'(m_pht[update_pht_index_i] + 2'd1);
            end else if (!update_taken_i && (m_pht[update_pht_index_i] != STRONG_NT)) begin
                m_pht[update_pht_index_i] = counter_e'(m_pht[update_pht_index_i] - 2'd1);
            end
        end
        if (ghr_clear_i) begin
            m_ghr = '0;
        end else if (is_branch) begin
            m_ghr = {m_ghr[GHR_BITS-2:0], update_taken_i};
        end
    endtask

    task automatic compare_model();
        logic [BTB_IDX_BITS-1:0] bidx;
        logic                    exp_hit;
        logic                    exp_taken;
        logic [XLEN-1:0]         exp_target;
        logic [GHR_BITS-1:0]     exp_index;
        bidx       = pc_i[WORD_LSB +: BTB_IDX_BITS];
        exp_hit    = m_valid[bidx] && (m_tag[bidx] == (pc_i >> (BTB_IDX_BITS + WORD_LSB)));
        exp_index  = pc_i[WORD_LSB +: GHR_BITS] ^ m_ghr;
        exp_taken  = exp_hit && (m_jump[bidx] || (m_branch[bidx] && m_pht[exp_index][1]));
        exp_target = exp_hit ? m_target[bidx] : '0;
        check_bit("hit_o", exp_hit, hit_o);
        check_bit("predict_taken_o", exp_taken, predict_taken_o);
        check_word("target_o", exp_target, target_o);
        check_index("pht_index_o", exp_index, pht_index_o);
    endtask

    task automatic drive(input logic [XLEN-1:0] pc, input logic uv, input logic [XLEN-1:0] upc,
                         input opcode_e op, input logic [XLEN-1:0] tgt, input logic taken,
                         input logic [GHR_BITS-1:0] pidx, input logic clr);
        pc_i               = pc;
        update_valid_i     = uv;
        update_pc_i        = upc;
        update_op_i        = op;
        update_target_i    = tgt;
        update_taken_i     = taken;
        update_pht_index_i = pidx;
        ghr_clear_i        = clr;
    endtask

    // One model-checked cycle from falling edge to falling edge.
    task automatic step(input logic [XLEN-1:0] pc, input logic uv, input logic [XLEN-1:0] upc,
                        input opcode_e op, input logic [XLEN-1:0] tgt, input logic taken,
                        input logic [GHR_BITS-1:0] pidx, input logic clr);
        drive(pc, uv, upc, op, tgt, taken, pidx, clr);
        #1;
        compare_model();
        model_apply();
        @(negedge clk);
    endtask

    task automatic probe(input logic [XLEN-1:0] pc, input logic exp_hit, input logic exp_taken,
                         input logic [XLEN-1:0] exp_target);
        drive(pc, 1'b0, '0, OP_OTHER, '0, 1'b0, '0, 1'b0);
        #1;
        compare_model();
        check_bit("hit_o", exp_hit, hit_o);
        check_bit("predict_taken_o", exp_taken, predict_taken_o);
        check_word("target_o", exp_target, target_o);
        model_apply();
        @(negedge clk);
    endtask

    task automatic index_probe(input logic [XLEN-1:0] pc, input logic [GHR_BITS-1:0] exp_index);
        drive(pc, 1'b0, '0, OP_OTHER, '0, 1'b0, '0, 1'b0);
        #1;
        compare_model();
        check_index("pht_index_o", exp_index, pht_index_o);
        model_apply();
        @(negedge clk);
    endtask

    task automatic reset_state();
        probe(32'h0000_0010, 1'b0, 1'b0, '0);
        index_probe(32'h0000_0010, 5'd4);
        probe(32'h0000_02a4, 1'b0, 1'b0, '0);
        index_probe(32'h0000_02a4, 5'd9);
    endtask

    task automatic jump_install();
        step('0, 1'b1, 32'h0000_0200, OP_JAL, 32'h0000_3000, 1'b1, '0, 1'b0);
        probe(32'h0000_0200, 1'b1, 1'b1, 32'h0000_3000);
        step('0, 1'b1, 32'h0000_0244, OP_JALR, 32'h0000_0800, 1'b1, '0, 1'b0);
        probe(32'h0000_0244, 1'b1, 1'b1, 32'h0000_0800);
        step('0, 1'b1, 32'h0000_0288, OP_OTHER, 32'h0000_0900, 1'b1, '0, 1'b0);
        probe(32'h0000_0288, 1'b0, 1'b0, '0);
    endtask

    // Branch at index 4 with the history cleared on every update.
    task automatic counter_training();
        step('0, 1'b0, '0, OP_OTHER, '0, 1'b0, '0, 1'b1);
        step('0, 1'b1, 32'h0000_0410, OP_BRANCH, 32'h0000_0100, 1'b0, 5'd4, 1'b1);
        probe(32'h0000_0410, 1'b1, 1'b0, 32'h0000_0100);
        for (int i = 1; i <= 4; i++) begin
            step('0, 1'b1, 32'h0000_0410, OP_BRANCH, 32'h0000_0100, 1'b1, 5'd4, 1'b1);
            probe(32'h0000_0410, 1'b1, (i >= 2), 32'h0000_0100);
        end
        for (int i = 1; i <= 2; i++) begin
            step('0, 1'b1, 32'h0000_0410, OP_BRANCH, 32'h0000_0100, 1'b0, 5'd4, 1'b1);
            probe(32'h0000_0410, 1'b1, (i < 2), 32'h0000_0100);
        end
    endtask

    task automatic history_indexing();
        logic [5:0] outcomes;
        outcomes = 6'b101101; // Oldest outcome first.
        step('0, 1'b0, '0, OP_OTHER, '0, 1'b0, '0, 1'b1);
        for (int i = 0; i < 6; i++) begin
            step('0, 1'b1, 32'h0000_0604, OP_BRANCH, 32'h0000_0700, outcomes[5-i], 5'd1, 1'b0);
        end
        index_probe(32'h0000_0010, 5'd4 ^ 5'b01101);
        index_probe(32'h0000_0604, 5'd1 ^ 5'b01101);
        step('0, 1'b1, 32'h0000_0604, OP_BRANCH, 32'h0000_0700, 1'b1, 5'd1, 1'b1);
        index_probe(32'h0000_0010, 5'd4);
        index_probe(32'h0000_0604, 5'd1);
    endtask

    // Both PCs map to BTB entry 16.
    task automatic btb_aliasing();
        step('0, 1'b1, 32'h0000_1040, OP_JAL, 32'h0000_2000, 1'b1, '0, 1'b0);
        probe(32'h0000_1040, 1'b1, 1'b1, 32'h0000_2000);
        probe(32'h0000_10c0, 1'b0, 1'b0, '0);
        step('0, 1'b1, 32'h0000_10c0, OP_JAL, 32'h0000_2400, 1'b1, '0, 1'b0);
        probe(32'h0000_1040, 1'b0, 1'b0, '0);
        probe(32'h0000_10c0, 1'b1, 1'b1, 32'h0000_2400);
    endtask

    task automatic random_mix();
        logic [31:0]         r;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     upc;
        logic [XLEN-1:0]     tgt;
        opcode_e             op;
        logic                uv;
        logic                taken;
        logic                clr;
        logic [GHR_BITS-1:0] pidx;
        for (int n = 0; n < 200; n++) begin
            r = rand_bits(6);
            pc = 32'h0000_0100 + {24'd0, r[5:0], 2'b00};
            r = rand_bits(6);
            upc = 32'h0000_0100 + {24'd0, r[5:0], 2'b00};
            r = rand_bits(2);
            case (r[1:0])
                2'd0:    op = OP_BRANCH;
                2'd1:    op = OP_JAL;
                2'd2:    op = OP_JALR;
                default: op = OP_OTHER;
            endcase
            r = rand_bits(1);
            uv = r[0];
            r = rand_bits(1);
            taken = r[0];
            r = rand_bits(8);
            tgt = 32'h0000_4000 + {22'd0, r[7:0], 2'b00};
            r = rand_bits(GHR_BITS);
            pidx = r[GHR_BITS-1:0];
            r = rand_bits(3);
            clr = &r[2:0]; // About one clear in eight cycles.
            step(pc, uv, upc, op, tgt, taken, pidx, clr);
        end
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        drive('0, 1'b0, '0, OP_OTHER, '0, 1'b0, '0, 1'b0);
        model_reset();
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        reset_state();
        jump_install();
        counter_training();
        history_indexing();
        btb_aliasing();
        random_mix();
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: project.f
source/branch_pkg.sv
source/branch_target_buffer.sv
source/gshare_predictor.sv
source/branch_predictor.sv
dv/branch_predictor_checker.sv
dv/branch_predictor_tb.sv

// File: source/branch_pkg.sv
// Package with the RISC-V opcode enum, the 2-bit counter enum and the prediction constants.
package branch_pkg;

    // Width of the PC and of the predicted target.
    localparam int XLEN = 32;

    // Instructions are word aligned, so table indexes start at PC bit 2.
    localparam int PC_LSB = 2;

    // RISC-V major opcodes seen by the predictor.
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // Conditional branch.
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OTHER  = 7'b0010011  // Any non control flow instruction.
    } opcode_e;

    // 2-bit saturating counter states.
    // The upper bit is the taken prediction.
    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } counter_e;

    // Counter state after reset.
    localparam counter_e COUNTER_RESET = WEAK_NT;

endpackage

// File: source/branch_predictor.sv
// Branch prediction unit top level combining the BTB and the gshare predictor.
`timescale 1ns/1ps

module branch_predictor import branch_pkg::*; #(
    parameter int btb_entries = 32,
    parameter int ghr_bits    = 5
) (
    input  logic                clk,
    input  logic                rst_n_i,

    // Fetch side.
    input  logic [XLEN-1:0]     pc_i,
    output logic                hit_o,
    output logic                predict_taken_o,
    output logic [XLEN-1:0]     target_o,
    output logic [ghr_bits-1:0] pht_index_o,

    // Execute side.
    input  logic                update_valid_i,
    input  logic [XLEN-1:0]     update_pc_i,
    input  opcode_e             update_op_i,
    input  logic [XLEN-1:0]     update_target_i,
    input  logic                update_taken_i,
    input  logic [ghr_bits-1:0] update_pht_index_i,
    input  logic                ghr_clear_i
);

    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            btb_is_jump;
    logic            btb_is_branch;
    logic            counter_taken;

    branch_target_buffer #(
        .btb_entries     (btb_entries)
    ) btb_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_i),
        .update_valid_i  (update_valid_i),
        .update_pc_i     (update_pc_i),
        .update_op_i     (update_op_i),
        .update_target_i (update_target_i),
        .hit_o           (btb_hit),
        .target_o        (btb_target),
        .is_jump_o       (btb_is_jump),
        .is_branch_o     (btb_is_branch)
    );

    gshare_predictor #(
        .ghr_bits           (ghr_bits)
    ) gshare_inst (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .pc_i               (pc_i),
        .update_valid_i     (update_valid_i),
        .update_op_i        (update_op_i),
        .update_taken_i     (update_taken_i),
        .update_pht_index_i (update_pht_index_i),
        .ghr_clear_i        (ghr_clear_i),
        .taken_o            (counter_taken),
        .pht_index_o        (pht_index_o)
    );

    assign hit_o = btb_hit;

    // Jumps are always taken, branches follow the counter.
    assign predict_taken_o = btb_hit && (btb_is_jump || (btb_is_branch && counter_taken));

    assign target_o = btb_hit ? btb_target : '0;

endmodule

// File: source/branch_target_buffer.sv
// Direct-mapped branch target buffer with tagged combinational lookup and update write port.
`timescale 1ns/1ps

module branch_target_buffer import branch_pkg::*; #(
    parameter int btb_entries = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            update_valid_i,
    input  logic [XLEN-1:0] update_pc_i,
    input  opcode_e         update_op_i,
    input  logic [XLEN-1:0] update_target_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o,
    output logic            is_jump_o,
    output logic            is_branch_o
);

    localparam int idx_bits = $clog2(btb_entries);
    localparam int tag_bits = XLEN - idx_bits - PC_LSB;

    logic                valid_q  [btb_entries];
    logic [tag_bits-1:0] tag_q    [btb_entries];
    logic [XLEN-1:0]     target_q [btb_entries];
    logic                jump_q   [btb_entries];
    logic                branch_q [btb_entries];

    logic [idx_bits-1:0] rd_idx;
    logic [tag_bits-1:0] rd_tag;
    logic [idx_bits-1:0] wr_idx;
    logic [tag_bits-1:0] wr_tag;
    logic                wr_jump;
    logic                wr_branch;
    logic                wr_en;
    logic                entry_match;

    // Lookup side.
    assign rd_idx = pc_i[PC_LSB +: idx_bits];
    assign rd_tag = pc_i[XLEN-1 -: tag_bits];

    // Update side.
    assign wr_idx = update_pc_i[PC_LSB +: idx_bits];
    assign wr_tag = update_pc_i[XLEN-1 -: tag_bits];

    always_comb begin
        wr_jump   = 1'b0;
        wr_branch = 1'b0;
        case (update_op_i)
            OP_BRANCH: wr_branch = 1'b1;
            OP_JAL,
            OP_JALR:   wr_jump   = 1'b1;
            default:   wr_jump   = 1'b0; // Not control flow, no write.
        endcase
    end

    assign wr_en = update_valid_i && (wr_jump || wr_branch);

    // Valid bits are the only BTB state cleared by reset.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload, overwritten on every control flow update.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= update_target_i;
            jump_q[wr_idx]   <= wr_jump;
            branch_q[wr_idx] <= wr_branch;
        end
    end

    assign entry_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    always_comb begin
        hit_o = entry_match;
        if (entry_match) begin
            target_o    = target_q[rd_idx];
            is_jump_o   = jump_q[rd_idx];
            is_branch_o = branch_q[rd_idx];
        end else begin
            target_o    = '0; // Miss reads as an empty entry.
            is_jump_o   = 1'b0;
            is_branch_o = 1'b0;
        end
    end

endmodule

// File: source/gshare_predictor.sv
// Gshare direction predictor with global history register and table of 2-bit counters.
`timescale 1ns/1ps

module gshare_predictor import branch_pkg::*; #(
    parameter int ghr_bits = 5
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic                update_valid_i,
    input  opcode_e             update_op_i,
    input  logic                update_taken_i,
    input  logic [ghr_bits-1:0] update_pht_index_i,
    input  logic                ghr_clear_i,
    output logic                taken_o,
    output logic [ghr_bits-1:0] pht_index_o
);

    localparam int pht_entries = 1 << ghr_bits;

    logic [ghr_bits-1:0] ghr_q;
    counter_e            pht_q [pht_entries];

    logic [ghr_bits-1:0] rd_idx;
    counter_e            rd_state;
    logic                train_en;
    counter_e            cur_state;
    counter_e            next_state;

    // One saturating step towards the resolved direction.
    function automatic counter_e counter_next(input counter_e state, input logic taken);
        counter_e result;
        result = state;
        if (taken) begin
            case (state)
                STRONG_NT: result = WEAK_NT;
                WEAK_NT:   result = WEAK_T;
                WEAK_T:    result = STRONG_T;
                STRONG_T:  result = STRONG_T;
            endcase
        end else begin
            case (state)
                STRONG_NT: result = STRONG_NT;
                WEAK_NT:   result = STRONG_NT;
                WEAK_T:    result = WEAK_NT;
                STRONG_T:  result = WEAK_T;
            endcase
        end
        return result;
    endfunction

    // Index is the word PC bits hashed with the history.
    assign rd_idx      = pc_i[PC_LSB +: ghr_bits] ^ ghr_q;
    assign rd_state    = pht_q[rd_idx];
    assign taken_o     = rd_state[1]; // Upper bit is the prediction.
    assign pht_index_o = rd_idx;

    assign train_en   = update_valid_i && (update_op_i == OP_BRANCH);
    assign cur_state  = pht_q[update_pht_index_i];
    assign next_state = counter_next(cur_state, update_taken_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht_q[i] <= COUNTER_RESET;
            end
        end else if (train_en) begin
            pht_q[update_pht_index_i] <= next_state; // Index carried back from fetch.
        end
    end

    // History, newest outcome in the LSB.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0; // Clear wins over a shift.
        end else if (train_en) begin
            ghr_q <= {ghr_q[ghr_bits-2:0], update_taken_i};
        end
    end

endmodule
